/* filelist.f */
proc_pkg.sv
fetch.sv
reg_file.sv
decode.sv
hazard_unit.sv
execute.sv
memory_stage.sv
proc.sv
tb_proc.sv

/* tb_proc.sv */
`timescale 1ns/1ps

// Testbench for the five-stage processor
// Builds random programs from an LFSR, runs each one through an ISA
// model and checks every retiring register write against it, then
// the halted and err flags. Two directed programs end the run with
// an undefined opcode and an odd load address
module tb_proc;

  import proc_pkg::*;

  localparam int NUM_RANDOM      = 6;
  localparam int NUM_PROGS       = NUM_RANDOM + 2;
  localparam int PROG_MAX        = 64;
  localparam int BODY_LEN        = 40;
  localparam int WATCHDOG_CYCLES = NUM_PROGS * (PROG_MAX * 6 + 40);

  logic        clk;
  logic        reset;
  logic [15:0] imem_addr;
  logic [15:0] imem_instr;
  logic        wb_valid;
  logic [2:0]  wb_reg;
  logic [15:0] wb_data;
  logic        halted;
  logic        err;

  logic [15:0] imem [256];
  logic [15:0] lfsr;
  wb_t         exp_q [$];

  proc #(
    .DMEM_WORDS (256)
  ) dut_i (
    .clk        (clk),
    .reset      (reset),
    .imem_addr  (imem_addr),
    .imem_instr (imem_instr),
    .wb_valid   (wb_valid),
    .wb_reg     (wb_reg),
    .wb_data    (wb_data),
    .halted     (halted),
    .err        (err)
  );

  // Instruction memory answers in the same cycle
  assign imem_instr = $isunknown(imem_addr) ? NOP_INSTR : imem[imem_addr[8:1]];

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[14:0], fb};
    end
    return v;
  endfunction

  function automatic logic [15:0] alu_word(input logic [2:0] rd, input logic [2:0] rs,
                                          input logic [2:0] rt, input logic [1:0] fn);
    return {OP_ALU, rs, rt, rd, fn};
  endfunction

  function automatic logic [15:0] imm_word(input opcode_e op, input logic [2:0] rs,
                                          input logic [2:0] r_mid, input logic [4:0] imm);
    return {op, rs, r_mid, imm};
  endfunction

  function automatic logic [15:0] beqz_word(input logic [2:0] rs, input logic [7:0] imm);
    return {OP_BEQZ, rs, imm};
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_wb(input wb_t exp);
    if (wb_reg !== exp.rd) begin
      fail_run($sformatf("mismatch at %0t: wb_reg expected %0d got %0d",
                         $time, exp.rd, wb_reg));
    end
    if (wb_data !== exp.data) begin
      fail_run($sformatf("mismatch at %0t: wb_data expected %h got %h",
                         $time, exp.data, wb_data));
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      fail_run($sformatf("mismatch at %0t: %s expected %b got %b",
                         $time, name, expected, actual));
    end
  endtask

  task automatic expect_idle();
    check_flag("wb_valid", wb_valid, 1'b0);
    check_flag("halted", halted, 1'b0);
    check_flag("err", err, 1'b0);
  endtask

  task automatic clear_imem();
    for (int i = 0; i < 256; i++) begin
      imem[i] = NOP_INSTR;
    end
  endtask

  // Register setup, random body with forward branches, then HALT
  task automatic build_random_program();
    logic       stored [16];
    logic [2:0] rd;
    logic [2:0] rs;
    logic [4:0] imm;
    int         n;
    int         shadow;
    int         span;
    int         kind;
    clear_imem();
    for (int i = 0; i < 16; i++) begin
      stored[i] = 1'b0;
    end
    n      = 0;
    shadow = 0;
    // Each setup ADDI depends on the one before
    imem[n] = imm_word(OP_ADDI, 3'd0, 3'd0, 5'(rand_bits(5)));
    n++;
    for (int r = 1; r < 7; r++) begin
      imem[n] = imm_word(OP_ADDI, 3'(r - 1), 3'(r), 5'(rand_bits(5)));
      n++;
    end
    // r7 is the memory base, kept even and never overwritten
    imem[n] = imm_word(OP_ADDI, 3'd7, 3'd7, 5'(rand_bits(4) << 1));
    n++;
    while (n < 8 + BODY_LEN || shadow > 0) begin
      kind = int'(rand_bits(3));
      // Only ALU and ADDI inside a branch shadow
      if (shadow > 0) begin
        kind = (kind % 2 == 0) ? 0 : 3;
        shadow--;
      end
      rd = 3'(rand_bits(3) % 7);
      rs = 3'(rand_bits(3));
      case (kind)
        0, 1, 2: begin
          imem[n] = alu_word(rd, rs, 3'(rand_bits(3)), 2'(rand_bits(2)));
        end
        3: begin
          imem[n] = imm_word(OP_ADDI, rs, rd, 5'(rand_bits(5)));
        end
        4, 5: begin
          imm = 5'(rand_bits(4) << 1);
          if (kind == 5 && stored[imm[4:1]]) begin
            imem[n] = imm_word(OP_LD, 3'd7, rd, imm);
          end else begin
            imem[n] = imm_word(OP_ST, 3'd7, rs, imm);
            stored[imm[4:1]] = 1'b1;
          end
        end
        default: begin
          span = int'(rand_bits(2) % 3) + 1;
          // Zero the tested register half the time so the branch is taken
          if (rand_bits(1) == 16'd1) begin
            imem[n] = alu_word(rd, rd, rd, FN_XOR);
            n++;
          end else begin
            rd = rs;
          end
          imem[n] = beqz_word(rd, 8'(span * 2));
          shadow  = span;
        end
      endcase
      n++;
    end
    imem[n] = {OP_HALT, 11'd0};
  endtask

  task automatic build_illegal_program();
    clear_imem();
    imem[0] = imm_word(OP_ADDI, 3'd0, 3'd1, 5'd3);
    imem[1] = {5'b00010, 11'h123};
    imem[2] = imm_word(OP_ADDI, 3'd1, 3'd2, 5'd4);
    imem[3] = {OP_HALT, 11'd0};
  endtask

  task automatic build_misaligned_program();
    clear_imem();
    imem[0] = imm_word(OP_ADDI, 3'd0, 3'd1, 5'd6);
    imem[1] = imm_word(OP_ADDI, 3'd0, 3'd2, 5'd11);
    imem[2] = imm_word(OP_ST, 3'd1, 3'd2, 5'd0);
    imem[3] = imm_word(OP_ADDI, 3'd1, 3'd3, 5'd1);
    // Address 7 is odd
    imem[4] = imm_word(OP_LD, 3'd3, 3'd4, 5'd0);
    imem[5] = {OP_HALT, 11'd0};
  endtask

  // ISA model of the program in imem, queues the register writes
  task automatic model_program(output logic exp_err);
    logic [15:0] regs [8];
    logic [15:0] mem [256];
    logic [15:0] pc;
    logic [15:0] instr;
    logic [15:0] addr;
    logic [15:0] value;
    logic [2:0]  rd;
    logic        write;
    logic        done;
    wb_t         exp;
    int          steps;
    for (int i = 0; i < 8; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      mem[i] = '0;
    end
    exp_q.delete();
    pc      = '0;
    exp_err = 1'b0;
    done    = 1'b0;
    steps   = 0;
    while (!done && steps < 256) begin
      instr = imem[pc[8:1]];
      pc    = pc + 16'd2;
      rd    = instr[7:5];
      write = 1'b0;
      value = '0;
      addr  = regs[instr[10:8]] + {{11{instr[4]}}, instr[4:0]};
      case (instr[15:11])
        OP_HALT: begin
          done = 1'b1;
        end
        OP_NOP: begin
        end
        OP_ADDI: begin
          value = addr;
          write = 1'b1;
        end
        OP_LD: begin
          exp_err = exp_err | addr[0];
          value   = mem[addr[8:1]];
          write   = 1'b1;
        end
        OP_ST: begin
          if (addr[0]) begin
            exp_err = 1'b1;
          end else begin
            mem[addr[8:1]] = regs[instr[7:5]];
          end
        end
        OP_BEQZ: begin
          if (regs[instr[10:8]] == 16'd0) begin
            pc = pc + {{8{instr[7]}}, instr[7:0]};
          end
        end
        OP_ALU: begin
          rd    = instr[4:2];
          write = 1'b1;
          case (instr[1:0])
            2'b00:   value = regs[instr[10:8]] + regs[instr[7:5]];
            2'b01:   value = regs[instr[10:8]] - regs[instr[7:5]];
            2'b10:   value = regs[instr[10:8]] ^ regs[instr[7:5]];
            default: value = regs[instr[10:8]] & regs[instr[7:5]];
          endcase
        end
        default: begin
          exp_err = 1'b1;
        end
      endcase
      if (write) begin
        regs[rd]      = value;
        exp.valid     = 1'b1;
        exp.reg_write = 1'b1;
        exp.rd        = rd;
        exp.data      = value;
        exp.halt      = 1'b0;
        exp_q.push_back(exp);
      end
      steps++;
    end
  endtask

  // Reset for 16 cycles, outputs must stay quiet throughout
  task automatic hold_reset();
    @(posedge clk);
    #10;
    reset = 1'b1;
    repeat (15) begin
      @(posedge clk);
      @(negedge clk);
      expect_idle();
    end
    @(posedge clk);
    #10;
    reset = 1'b0;
    @(negedge clk);
    expect_idle();
  endtask

  task automatic run_program(input logic exp_err);
    wb_t  exp;
    logic done;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (wb_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          fail_run($sformatf("unexpected register write to r%0d at %0t", wb_reg, $time));
        end else begin
          exp = exp_q.pop_front();
          check_wb(exp);
        end
      end else begin
        check_flag("wb_valid", wb_valid, 1'b0);
      end
      done = (halted === 1'b1);
    end
    if (exp_q.size() != 0) begin
      fail_run($sformatf("halted at %0t with %0d register writes still missing",
                         $time, exp_q.size()));
    end
    check_flag("err", err, exp_err);
    // Nothing retires after HALT
    repeat (20) begin
      @(negedge clk);
      check_flag("wb_valid", wb_valid, 1'b0);
    end
  endtask

  initial begin
    logic exp_err;
    reset = 1'b1;
    lfsr  = 16'd59;
    clear_imem();
    for (int p = 0; p < NUM_PROGS; p++) begin
      if (p < NUM_RANDOM) begin
        build_random_program();
      end else if (p == NUM_RANDOM) begin
        build_illegal_program();
      end else begin
        build_misaligned_program();
      end
      model_program(exp_err);
      hold_reset();
      run_program(exp_err);
    end
    $display("TB PASSED");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    fail_run($sformatf("timeout, run did not finish within %0d cycles", WATCHDOG_CYCLES));
  end

endmodule

/* proc.sv */
`timescale 1ns/1ps

// Five-stage pipelined processor top level
// Connects fetch, decode with its register file and hazard unit,
// execute and the memory stage. Instruction memory sits outside and
// answers imem_addr in the same cycle. Retiring register writes show
// up on the trace ports
module proc #(
  parameter int DMEM_WORDS = proc_pkg::DMEM_WORDS_DEF
) (
  input  logic        clk,
  input  logic        reset,
  output logic [15:0] imem_addr,
  input  logic [15:0] imem_instr,
  output logic        wb_valid,
  output logic [2:0]  wb_reg,
  output logic [15:0] wb_data,
  output logic        halted,
  output logic        err
);

  import proc_pkg::*;

  if_id_t      if_id;
  id_ex_t      id_ex;
  ex_mem_t     ex_mem;
  wb_t         wb;
  branch_t     branch;
  logic [2:0]  rs_addr;
  logic [2:0]  rt_addr;
  logic [15:0] rs_data;
  logic [15:0] rt_data;
  logic        uses_rs;
  logic        uses_rt;
  logic        stall;
  logic        halt_seen;
  logic        illegal;

  fetch fetch_i (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .halt_seen  (halt_seen),
    .branch     (branch),
    .imem_instr (imem_instr),
    .imem_addr  (imem_addr),
    .if_id      (if_id)
  );

  reg_file reg_file_i (
    .clk     (clk),
    .reset   (reset),
    .rs_addr (rs_addr),
    .rt_addr (rt_addr),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .wb      (wb)
  );

  // Taken branch flushes the instruction in decode
  decode decode_i (
    .clk       (clk),
    .reset     (reset),
    .if_id     (if_id),
    .stall     (stall),
    .flush     (branch.taken),
    .rs_data   (rs_data),
    .rt_data   (rt_data),
    .rs_addr   (rs_addr),
    .rt_addr   (rt_addr),
    .uses_rs   (uses_rs),
    .uses_rt   (uses_rt),
    .id_ex     (id_ex),
    .halt_seen (halt_seen),
    .illegal   (illegal)
  );

  hazard_unit hazard_unit_i (
    .rs_addr (rs_addr),
    .rt_addr (rt_addr),
    .uses_rs (uses_rs),
    .uses_rt (uses_rt),
    .id_ex   (id_ex),
    .ex_mem  (ex_mem),
    .stall   (stall)
  );

  execute execute_i (
    .clk    (clk),
    .reset  (reset),
    .id_ex  (id_ex),
    .branch (branch),
    .ex_mem (ex_mem)
  );

  memory_stage #(
    .DMEM_WORDS (DMEM_WORDS)
  ) memory_stage_i (
    .clk        (clk),
    .reset      (reset),
    .ex_mem     (ex_mem),
    .illegal    (illegal),
    .wb         (wb),
    .misaligned (),
    .halted     (halted),
    .err        (err)
  );

  // Trace only register writes
  assign wb_valid = wb.valid && wb.reg_write;
  assign wb_reg   = wb_valid ? wb.rd : 3'd0;
  assign wb_data  = wb_valid ? wb.data : 16'd0;

endmodule

/* memory_stage.sv */
`timescale 1ns/1ps

// Memory and writeback stage
// Word-indexed data memory, misalignment check, load/ALU select and
// the MEM/WB register. Also keeps the sticky halted and err flags
module memory_stage #(
  parameter int DMEM_WORDS = proc_pkg::DMEM_WORDS_DEF
) (
  input  logic              clk,
  input  logic              reset,
  input  proc_pkg::ex_mem_t ex_mem,
  input  logic              illegal,
  output proc_pkg::wb_t     wb,
  output logic              misaligned,
  output logic              halted,
  output logic              err
);

  import proc_pkg::*;

  localparam int IDX_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

  logic [15:0]      dmem [DMEM_WORDS];
  logic [IDX_W-1:0] word_idx;
  logic             access;

  // Halfword address to word index, wrapped to the memory depth
  assign word_idx   = IDX_W'((ex_mem.result >> 1) % DMEM_WORDS);
  assign access     = ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write);
  assign misaligned = access && ex_mem.result[0];

  always_ff @(posedge clk) begin
    if (ex_mem.valid && ex_mem.mem_write && !misaligned) begin
      dmem[word_idx] <= ex_mem.store_data;
    end
  end

  // MEM/WB register with the writeback select folded in
  always_ff @(posedge clk) begin
    if (reset) begin
      wb.valid <= 1'b0;
    end else begin
      wb.valid     <= ex_mem.valid;
      wb.reg_write <= ex_mem.reg_write;
      wb.rd        <= ex_mem.rd;
      wb.data      <= ex_mem.mem_read ? dmem[word_idx] : ex_mem.result;
      wb.halt      <= (ex_mem.op == OP_HALT);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      halted <= 1'b0;
      err    <= 1'b0;
    end else begin
      halted <= halted || (wb.valid && wb.halt);
      err    <= err || illegal || misaligned;
    end
  end

  // Execute drives at most one of the two memory controls
  one_mem_op: assert property (@(posedge clk) disable iff (reset)
    ex_mem.valid |-> !(ex_mem.mem_read && ex_mem.mem_write))
    else $error("memory_stage: read and write in the same access");

endmodule

/* execute.sv */
`timescale 1ns/1ps

// Execute stage
// ALU for the register-register functions, address add for ADDI,
// LD and ST, and BEQZ resolution. The branch decision is driven
// combinationally so fetch and decode can flush on the next edge
module execute (
  input  logic              clk,
  input  logic              reset,
  input  proc_pkg::id_ex_t  id_ex,
  output proc_pkg::branch_t branch,
  output proc_pkg::ex_mem_t ex_mem
);

  import proc_pkg::*;

  logic [15:0] alu_out;
  logic [15:0] addr_sum;
  logic [15:0] target;
  logic [15:0] result;
  logic        taken;

  always_comb begin
    case (id_ex.func)
      FN_ADD:  alu_out = id_ex.a + id_ex.b;
      FN_SUB:  alu_out = id_ex.a - id_ex.b;
      FN_XOR:  alu_out = id_ex.a ^ id_ex.b;
      default: alu_out = id_ex.a & id_ex.b;
    endcase
  end

  assign addr_sum = id_ex.a + id_ex.imm;
  assign target   = id_ex.pc_next + id_ex.imm;

  // Predicted not taken, so only a taken BEQZ redirects
  assign taken  = id_ex.valid && (id_ex.op == OP_BEQZ) && (id_ex.a == 16'd0);
  assign branch = '{taken: taken, target: target};

  always_comb begin
    case (id_ex.op)
      OP_ALU:               result = alu_out;
      OP_ADDI, OP_LD, OP_ST: result = addr_sum;
      OP_BEQZ:              result = target;
      default:              result = 16'd0;
    endcase
  end

  // EX/MEM register
  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem.valid <= 1'b0;
    end else begin
      ex_mem.valid      <= id_ex.valid;
      ex_mem.op         <= id_ex.op;
      ex_mem.rd         <= id_ex.rd;
      ex_mem.reg_write  <= id_ex.reg_write;
      ex_mem.result     <= result;
      ex_mem.store_data <= id_ex.b;
      ex_mem.mem_read   <= (id_ex.op == OP_LD);
      ex_mem.mem_write  <= (id_ex.op == OP_ST);
    end
  end

endmodule

/* hazard_unit.sv */
`timescale 1ns/1ps

// Read-after-write hazard detection
// Compares the sources of the instruction in decode against the
// destinations still in ID/EX and EX/MEM. Results in MEM/WB reach
// decode through the register file bypass, so they need no stall
module hazard_unit (
  input  logic              [2:0] rs_addr,
  input  logic              [2:0] rt_addr,
  input  logic                    uses_rs,
  input  logic                    uses_rt,
  input  proc_pkg::id_ex_t        id_ex,
  input  proc_pkg::ex_mem_t       ex_mem,
  output logic                    stall
);

  logic ex_hit;
  logic mem_hit;

  // True when either decode source reads the given register
  function automatic logic reads_reg(input logic [2:0] dest, input logic [2:0] rs,
                                     input logic [2:0] rt, input logic use_rs,
                                     input logic use_rt);
    return (use_rs && (rs == dest)) || (use_rt && (rt == dest));
  endfunction

  assign ex_hit = id_ex.valid && id_ex.reg_write &&
                  reads_reg(id_ex.rd, rs_addr, rt_addr, uses_rs, uses_rt);

  assign mem_hit = ex_mem.valid && ex_mem.reg_write &&
                   reads_reg(ex_mem.rd, rs_addr, rt_addr, uses_rs, uses_rt);

  assign stall = ex_hit || mem_hit;

endmodule

/* decode.sv */
`timescale 1ns/1ps

// Instruction decode stage
// Splits the instruction fields, extends the immediate, picks the
// destination and control bits and loads the ID/EX register.
// Inserts a bubble on stall or flush, flags undefined opcodes and
// remembers a decoded HALT so that fetch stops
module decode (
  input  logic             clk,
  input  logic             reset,
  input  proc_pkg::if_id_t if_id,
  input  logic             stall,
  input  logic             flush,
  input  logic [15:0]      rs_data,
  input  logic [15:0]      rt_data,
  output logic [2:0]       rs_addr,
  output logic [2:0]       rt_addr,
  output logic             uses_rs,
  output logic             uses_rt,
  output proc_pkg::id_ex_t id_ex,
  output logic             halt_seen,
  output logic             illegal
);

  import proc_pkg::*;

  opcode_e     op;
  logic        legal;
  logic        rs_needed;
  logic        rt_needed;
  logic        halt_q;
  logic        halt_now;
  logic [15:0] imm5_ext;
  logic [15:0] imm8_ext;
  id_ex_t      id_ex_next;

  assign op       = opcode_e'(if_id.instr[15:11]);
  assign rs_addr  = if_id.instr[10:8];
  assign rt_addr  = if_id.instr[7:5];
  assign imm5_ext = {{11{if_id.instr[4]}}, if_id.instr[4:0]};
  assign imm8_ext = {{8{if_id.instr[7]}}, if_id.instr[7:0]};

  // Source usage and opcode check
  always_comb begin
    legal     = 1'b1;
    rs_needed = 1'b0;
    rt_needed = 1'b0;
    case (op)
      OP_HALT, OP_NOP: begin
      end
      OP_ADDI, OP_LD, OP_BEQZ: begin
        rs_needed = 1'b1;
      end
      OP_ST, OP_ALU: begin
        rs_needed = 1'b1;
        rt_needed = 1'b1;
      end
      default: begin
        legal = 1'b0;
      end
    endcase
  end

  assign uses_rs = if_id.valid && rs_needed;
  assign uses_rt = if_id.valid && rt_needed;
  assign illegal = if_id.valid && !legal && !flush;

  // HALT is only honoured if the branch in execute does not kill it
  assign halt_now  = if_id.valid && (op == OP_HALT) && !flush;
  assign halt_seen = halt_q || halt_now;

  always_comb begin
    id_ex_next.valid   = if_id.valid && legal && !stall && !flush;
    id_ex_next.op      = op;
    id_ex_next.func    = alu_func_e'(if_id.instr[1:0]);
    id_ex_next.a       = rs_data;
    id_ex_next.b       = rt_data;
    id_ex_next.imm     = (op == OP_BEQZ) ? imm8_ext : imm5_ext;
    id_ex_next.pc_next = if_id.pc + 16'd2;
    case (op)
      OP_ALU: begin
        id_ex_next.rd        = if_id.instr[4:2];
        id_ex_next.reg_write = 1'b1;
      end
      OP_ADDI, OP_LD: begin
        id_ex_next.rd        = if_id.instr[7:5];
        id_ex_next.reg_write = 1'b1;
      end
      default: begin
        id_ex_next.rd        = 3'd0;
        id_ex_next.reg_write = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      id_ex.valid <= 1'b0;
      halt_q      <= 1'b0;
    end else begin
      id_ex  <= id_ex_next;
      halt_q <= halt_seen;
    end
  end

endmodule

/* reg_file.sv */
`timescale 1ns/1ps

// Register file
// Eight 16-bit registers, two combinational read ports and one
// write port fed by writeback. A write in progress is bypassed to
// a read of the same register in the same cycle
module reg_file (
  input  logic          clk,
  input  logic          reset,
  input  logic [2:0]    rs_addr,
  input  logic [2:0]    rt_addr,
  output logic [15:0]   rs_data,
  output logic [15:0]   rt_data,
  input  proc_pkg::wb_t wb
);

  logic [15:0] regs [8];
  logic        wr_en;

  assign wr_en = wb.valid && wb.reg_write;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // Read ports with write-through
  always_comb begin
    rs_data = regs[rs_addr];
    if (wr_en && (wb.rd == rs_addr)) begin
      rs_data = wb.data;
    end
  end

  always_comb begin
    rt_data = regs[rt_addr];
    if (wr_en && (wb.rd == rt_addr)) begin
      rt_data = wb.data;
    end
  end

endmodule

/* fetch.sv */
`timescale 1ns/1ps

// Instruction fetch stage
// Keeps the program counter, drives the instruction memory address
// and loads the IF/ID register. Holds on a decode stall, stops once
// HALT has been decoded, and redirects on a taken branch
module fetch (
  input  logic              clk,
  input  logic              reset,
  input  logic              stall,
  input  logic              halt_seen,
  input  proc_pkg::branch_t branch,
  input  logic [15:0]       imem_instr,
  output logic [15:0]       imem_addr,
  output proc_pkg::if_id_t  if_id
);

  import proc_pkg::*;

  logic [15:0] pc;

  assign imem_addr = pc;

  // Program counter, a taken branch wins over stall and halt
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (branch.taken) begin
      pc <= branch.target;
    end else if (!stall && !halt_seen) begin
      pc <= pc + 16'd2;
    end
  end

  // IF/ID register
  always_ff @(posedge clk) begin
    if (reset) begin
      if_id.valid <= 1'b0;
    end else if (branch.taken || (halt_seen && !stall)) begin
      // Kill the slot behind a redirect or after HALT
      if_id.valid <= 1'b0;
      if_id.instr <= NOP_INSTR;
    end else if (!stall) begin
      if_id.valid <= 1'b1;
      if_id.pc    <= pc;
      if_id.instr <= imem_instr;
    end
  end

  // Branch targets from execute must keep the pc halfword aligned
  pc_even: assert property (@(posedge clk) disable iff (reset) !pc[0])
    else $error("fetch: odd pc %h", pc);

endmodule

/* proc_pkg.sv */
// Shared definitions for the five-stage 16-bit pipeline
// Opcode and ALU function encodings, instruction field layout
// and the records that travel between the pipeline stages
package proc_pkg;

  // Instruction field layout
  //   [15:11]  opcode, all formats
  //   ALU         rs [10:8]  rt [7:5]     rd [4:2]  func [1:0]
  //   ADDI/LD/ST  rs [10:8]  rd/rt [7:5]  imm5 [4:0], signed
  //   BEQZ        rs [10:8]  imm8 [7:0], signed, added to pc+2
  // ST reads its data register from [7:5]

  typedef enum logic [4:0] {
    OP_HALT = 5'b00000,
    OP_NOP  = 5'b00001,
    OP_ADDI = 5'b01000,
    OP_BEQZ = 5'b01100,
    OP_ST   = 5'b10000,
    OP_LD   = 5'b10001,
    OP_ALU  = 5'b11011
  } opcode_e;

  typedef enum logic [1:0] {
    FN_ADD = 2'b00,
    FN_SUB = 2'b01,
    FN_XOR = 2'b10,
    FN_AND = 2'b11
  } alu_func_e;

  // Inserted by fetch when the IF/ID slot is killed
  localparam logic [15:0] NOP_INSTR = {OP_NOP, 11'd0};

  localparam int DMEM_WORDS_DEF = 256;

  typedef struct packed {
    logic        valid;
    logic [15:0] pc;
    logic [15:0] instr;
  } if_id_t;

  typedef struct packed {
    logic        valid;
    opcode_e     op;
    alu_func_e   func;
    logic [2:0]  rd;
    logic        reg_write;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] imm;
    logic [15:0] pc_next;
  } id_ex_t;

  typedef struct packed {
    logic        valid;
    opcode_e     op;
    logic [2:0]  rd;
    logic        reg_write;
    logic [15:0] result;
    logic [15:0] store_data;
    logic        mem_read;
    logic        mem_write;
  } ex_mem_t;

  typedef struct packed {
    logic        valid;
    logic        reg_write;
    logic [2:0]  rd;
    logic [15:0] data;
    logic        halt;
  } wb_t;

  typedef struct packed {
    logic        taken;
    logic [15:0] target;
  } branch_t;

endpackage
